/* logic/soc_pkg.sv */
/*
 * Sizes and command encoding shared across the LED PWM SoC.
 * The baud divider assumes the 25 MHz board clock, which gives 1 Mbaud.
 */
`default_nettype none

package soc_pkg;

    localparam int NUM_CHANNELS = 8;
    localparam int CHAN_W       = 3;     // Index width for NUM_CHANNELS
    localparam int DUTY_W       = 8;     // Duty and PWM counter width

    // UART timing
    localparam int CLKS_PER_BIT = 25;
    localparam int BAUD_W       = $clog2(CLKS_PER_BIT);

    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLKS_PER_BIT - 1);
    localparam logic [BAUD_W-1:0] BAUD_MID  = BAUD_W'(CLKS_PER_BIT / 2 - 1);

    // Opcode field of the command header byte
    typedef enum logic [3:0] {
        OP_NOP      = 4'd0,
        OP_SET_DUTY = 4'd1,
        OP_GET_DUTY = 4'd2
    } op_e;

    // Dispatcher to channel command of 12 bits
    typedef struct packed {
        op_e               op;
        logic [DUTY_W-1:0] data;
    } chan_cmd_t;

endpackage

`default_nettype wire

/* logic/uart_rx.sv */
/*
 * 8N1 receiver that puts out one byte per good frame and takes no back-pressure.
 * A false start or a bad stop bit drops the frame silently.
 */
`timescale 1ns/1ps
`default_nettype none

module uart_rx import soc_pkg::*; (
    input  wire logic       clk_25mhz,
    input  wire logic       rst_n_i,
    input  wire logic       rx_i,
    output      logic [7:0] byte_o,
    output      logic       valid_o
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e         state_q;
    logic [BAUD_W-1:0] baud_q;
    logic [2:0]        bit_q;
    logic [7:0]        shift_q;
    logic              rx_meta_q;
    logic              rx_q;

    // Two-flop pin synchronizer that idles high
    always_ff @(posedge clk_25mhz) begin
        if (!rst_n_i) begin
            rx_meta_q <= 1'b1;
            rx_q      <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_q      <= rx_meta_q;
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (!rst_n_i) begin
            state_q <= RX_IDLE;
            baud_q  <= '0;
            bit_q   <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            baud_q  <= baud_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    baud_q <= '0;
                    if (!rx_q) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (baud_q == BAUD_MID) begin        // Middle of start bit
                        baud_q  <= '0;
                        bit_q   <= '0;
                        state_q <= rx_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (baud_q == BAUD_LAST) begin
                        baud_q <= '0;
                        bit_q  <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (baud_q == BAUD_LAST) begin
                        state_q <= RX_IDLE;
                        valid_o <= rx_q;                 // Stop bit must be high
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk_25mhz) begin
        if (state_q == RX_DATA && baud_q == BAUD_LAST) begin
            shift_q <= {rx_q, shift_q[7:1]};
        end
    end

    assign byte_o = shift_q;  // Stable until next frame's data bits

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
/*
 * 8N1 transmitter. start_i is ignored while busy_o is high.
 * busy_o drops right after the full stop bit.
 */
`timescale 1ns/1ps
`default_nettype none

module uart_tx import soc_pkg::*; (
    input  wire logic       clk_25mhz,
    input  wire logic       rst_n_i,
    input  wire logic       start_i,
    input  wire logic [7:0] byte_i,
    output      logic       tx_o,
    output      logic       busy_o
);

    logic [9:0]        frame_q;  // Stop, data, start
    logic [BAUD_W-1:0] baud_q;
    logic [3:0]        bit_q;

    always_ff @(posedge clk_25mhz) begin
        if (!rst_n_i) begin
            busy_o <= 1'b0;
            baud_q <= '0;
            bit_q  <= '0;
        end else if (!busy_o) begin
            busy_o <= start_i;
            baud_q <= '0;
            bit_q  <= '0;
        end else if (baud_q == BAUD_LAST) begin
            baud_q <= '0;
            bit_q  <= bit_q + 1'b1;
            if (bit_q == 4'd9) begin
                busy_o <= 1'b0;         // Stop bit done
            end
        end else begin
            baud_q <= baud_q + 1'b1;
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (!busy_o && start_i) begin
            frame_q <= {1'b1, byte_i, 1'b0};
        end else if (busy_o && baud_q == BAUD_LAST) begin
            frame_q <= {1'b1, frame_q[9:1]};
        end
    end

    // Line idles high
    assign tx_o = busy_o ? frame_q[0] : 1'b1;

endmodule

`default_nettype wire

/* logic/cmd_dispatch.sv */
/*
 * Pairs header and data bytes into commands and issues one per channel credit.
 * While a frame waits for its channel's credit, incoming bytes are dropped.
 */
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch import soc_pkg::*; (
    input  wire logic                    clk_25mhz,
    input  wire logic                    rst_n_i,
    input  wire logic [7:0]              rx_byte_i,
    input  wire logic                    rx_valid_i,
    output      chan_cmd_t               cmd_o,
    output      logic [NUM_CHANNELS-1:0] cmd_valid_o,
    input  wire logic [NUM_CHANNELS-1:0] cmd_credit_i
);

    typedef enum logic [1:0] {
        FR_HEAD,
        FR_DATA,
        FR_HOLD
    } frame_state_e;

    frame_state_e            state_q;
    logic [7:0]              hdr_q;
    chan_cmd_t               pend_q;
    logic [CHAN_W-1:0]       pend_chan_q;
    logic [NUM_CHANNELS-1:0] credit_q;

    op_e                     hdr_op;
    logic [CHAN_W-1:0]       hdr_chan;
    logic                    hdr_ok;
    logic                    issue_new;
    logic                    issue_pend;
    logic [NUM_CHANNELS-1:0] issue;

    // Opcode sits in header bits [7:4] and the channel in [3:0]
    assign hdr_op   = op_e'(hdr_q[7:4]);
    assign hdr_chan = hdr_q[CHAN_W-1:0];
    assign hdr_ok   = (hdr_op == OP_SET_DUTY || hdr_op == OP_GET_DUTY) &&
                      (hdr_q[3:0] < 4'(NUM_CHANNELS));

    assign issue_new  = (state_q == FR_DATA) && rx_valid_i && hdr_ok && credit_q[hdr_chan];
    assign issue_pend = (state_q == FR_HOLD) && credit_q[pend_chan_q];

    always_comb begin
        issue = '0;
        if (issue_new) begin
            issue[hdr_chan] = 1'b1;
        end
        if (issue_pend) begin
            issue[pend_chan_q] = 1'b1;
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (!rst_n_i) begin
            state_q     <= FR_HEAD;
            credit_q    <= '1;
            cmd_valid_o <= '0;
        end else begin
            cmd_valid_o <= issue;
            credit_q    <= (credit_q | cmd_credit_i) & ~issue;
            case (state_q)
                FR_HEAD: begin
                    if (rx_valid_i) begin
                        state_q <= FR_DATA;
                    end
                end
                FR_DATA: begin
                    if (rx_valid_i) begin
                        // Bad frames and immediate issues both restart
                        state_q <= (!hdr_ok || issue_new) ? FR_HEAD : FR_HOLD;
                    end
                end
                FR_HOLD: begin
                    if (issue_pend) begin
                        state_q <= FR_HEAD;
                    end
                end
                default: state_q <= FR_HEAD;
            endcase
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (state_q == FR_HEAD && rx_valid_i) begin
            hdr_q <= rx_byte_i;
        end
        if (state_q == FR_DATA && rx_valid_i) begin
            pend_q      <= chan_cmd_t'{op: hdr_op, data: rx_byte_i};
            pend_chan_q <= hdr_chan;
        end
        if (issue_new) begin
            cmd_o <= chan_cmd_t'{op: hdr_op, data: rx_byte_i};
        end else if (issue_pend) begin
            cmd_o <= pend_q;
        end
    end

endmodule

`default_nettype wire

/* logic/pwm_channel.sv */
/*
 * One LED channel. The LED is on while the free-running counter is below duty,
 * so over any 256 cycles it is on for exactly duty cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module pwm_channel import soc_pkg::*; (
    input  wire logic       clk_25mhz,
    input  wire logic       rst_n_i,
    input  wire chan_cmd_t  cmd_i,
    input  wire logic       cmd_valid_i,
    output      logic       cmd_credit_o,
    output      logic [7:0] rep_byte_o,
    output      logic       rep_valid_o,
    input  wire logic       rep_credit_i,
    output      logic       led_o
);

    logic [DUTY_W-1:0] duty_q;
    logic [DUTY_W-1:0] cnt_q;
    logic              get_pend_q;
    logic              rep_credit_q;
    logic              send_rep;

    assign send_rep = get_pend_q && rep_credit_q;  // Reply slot free in merger
    assign led_o    = cnt_q < duty_q;

    always_ff @(posedge clk_25mhz) begin
        if (!rst_n_i) begin
            duty_q       <= '0;
            cnt_q        <= '0;
            get_pend_q   <= 1'b0;
            rep_credit_q <= 1'b1;
            cmd_credit_o <= 1'b0;
            rep_valid_o  <= 1'b0;
        end else begin
            cnt_q        <= cnt_q + 1'b1;
            cmd_credit_o <= send_rep;
            rep_valid_o  <= send_rep;
            rep_credit_q <= (rep_credit_q & ~send_rep) | rep_credit_i;
            if (send_rep) begin
                get_pend_q <= 1'b0;
            end
            if (cmd_valid_i) begin
                case (cmd_i.op)
                    OP_SET_DUTY: begin
                        duty_q       <= cmd_i.data;
                        cmd_credit_o <= 1'b1;
                    end
                    OP_GET_DUTY: get_pend_q <= 1'b1;
                    default:     cmd_credit_o <= 1'b1;  // Nothing to do
                endcase
            end
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (send_rep) begin
            rep_byte_o <= duty_q;
        end
    end

endmodule

`default_nettype wire

/* logic/reply_merge.sv */
/*
 * One-byte slot per channel, drained round-robin into the transmitter.
 * Search starts after the last channel served.
 */
`timescale 1ns/1ps
`default_nettype none

module reply_merge import soc_pkg::*; (
    input  wire logic                    clk_25mhz,
    input  wire logic                    rst_n_i,
    input  wire logic [7:0]              rep_byte_i [NUM_CHANNELS],
    input  wire logic [NUM_CHANNELS-1:0] rep_valid_i,
    output      logic [NUM_CHANNELS-1:0] rep_credit_o,
    input  wire logic                    tx_busy_i,
    output      logic                    tx_start_o,
    output      logic [7:0]              tx_byte_o
);

    logic [7:0]              slot_q [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] full_q;
    logic [CHAN_W-1:0]       last_q;
    logic [CHAN_W-1:0]       pick;
    logic                    pick_ok;
    logic                    grant;

    // Round-robin search from last_q + 1
    always_comb begin
        logic [CHAN_W-1:0] idx;
        pick    = last_q;
        pick_ok = 1'b0;
        for (int i = 1; i <= NUM_CHANNELS; i++) begin
            idx = CHAN_W'(last_q + i);
            if (!pick_ok && full_q[idx]) begin
                pick    = idx;
                pick_ok = 1'b1;
            end
        end
    end

    // tx_start_o covers the cycle before busy rises
    assign grant = pick_ok && !tx_busy_i && !tx_start_o;

    always_ff @(posedge clk_25mhz) begin
        if (!rst_n_i) begin
            full_q       <= '0;
            last_q       <= CHAN_W'(NUM_CHANNELS - 1);  // Channel 0 first
            tx_start_o   <= 1'b0;
            rep_credit_o <= '0;
        end else begin
            tx_start_o   <= grant;
            rep_credit_o <= '0;
            full_q       <= full_q | rep_valid_i;
            if (grant) begin
                full_q[pick]       <= 1'b0;
                rep_credit_o[pick] <= 1'b1;
                last_q             <= pick;
            end
        end
    end

    always_ff @(posedge clk_25mhz) begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (rep_valid_i[c]) begin
                slot_q[c] <= rep_byte_i[c];
            end
        end
        if (grant) begin
            tx_byte_o <= slot_q[pick];
        end
    end

endmodule

`default_nettype wire

/* logic/soc_top.sv */
/*
 * UART-controlled LED PWM SoC on a single clock domain.
 * Frame is header (opcode, channel) then data byte; GET replies one byte.
 */
`timescale 1ns/1ps
`default_nettype none

module soc_top import soc_pkg::*; (
    input  wire logic                    clk_25mhz,
    input  wire logic                    rst_n_i,
    input  wire logic                    rx_i,
    output      logic                    tx_o,
    output      logic [NUM_CHANNELS-1:0] led_o
);

    logic [7:0]              rx_byte;
    logic                    rx_valid;
    chan_cmd_t               chan_cmd;
    logic [NUM_CHANNELS-1:0] cmd_valid;
    logic [NUM_CHANNELS-1:0] cmd_credit;
    logic [7:0]              rep_byte [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] rep_valid;
    logic [NUM_CHANNELS-1:0] rep_credit;
    logic                    tx_start;
    logic [7:0]              tx_byte;
    logic                    tx_busy;

    uart_rx i_uart_rx (
        .clk_25mhz (clk_25mhz),
        .rst_n_i   (rst_n_i),
        .rx_i      (rx_i),
        .byte_o    (rx_byte),
        .valid_o   (rx_valid)
    );

    cmd_dispatch i_cmd_dispatch (
        .clk_25mhz    (clk_25mhz),
        .rst_n_i      (rst_n_i),
        .rx_byte_i    (rx_byte),
        .rx_valid_i   (rx_valid),
        .cmd_o        (chan_cmd),
        .cmd_valid_o  (cmd_valid),
        .cmd_credit_i (cmd_credit)
    );

    // One PWM channel per LED
    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
        pwm_channel i_pwm_channel (
            .clk_25mhz    (clk_25mhz),
            .rst_n_i      (rst_n_i),
            .cmd_i        (chan_cmd),
            .cmd_valid_i  (cmd_valid[g]),
            .cmd_credit_o (cmd_credit[g]),
            .rep_byte_o   (rep_byte[g]),
            .rep_valid_o  (rep_valid[g]),
            .rep_credit_i (rep_credit[g]),
            .led_o        (led_o[g])
        );
    end

    reply_merge i_reply_merge (
        .clk_25mhz    (clk_25mhz),
        .rst_n_i      (rst_n_i),
        .rep_byte_i   (rep_byte),
        .rep_valid_i  (rep_valid),
        .rep_credit_o (rep_credit),
        .tx_busy_i    (tx_busy),
        .tx_start_o   (tx_start),
        .tx_byte_o    (tx_byte)
    );

    uart_tx i_uart_tx (
        .clk_25mhz (clk_25mhz),
        .rst_n_i   (rst_n_i),
        .start_i   (tx_start),
        .byte_i    (tx_byte),
        .tx_o      (tx_o),
        .busy_o    (tx_busy)
    );

endmodule

`default_nettype wire

/* logic/board_top.sv */
/*
 * ULX3S wrapper that runs everything on clk_25mhz with no PLL.
 * btn_i[0] is the active-low reset, fed straight in, and btn_i[6:1] are unused.
 */
`timescale 1ns/1ps
`default_nettype none

module board_top (
    input  wire logic       clk_25mhz,   // 25 MHz board oscillator
    input  wire logic [6:0] btn_i,
    input  wire logic       ftdi_txd_i,  // Host to FPGA
    output      logic       ftdi_rxd_o,  // FPGA to host
    output      logic [7:0] led_o
);

    soc_top i_soc_top (
        .clk_25mhz (clk_25mhz),
        .rst_n_i   (btn_i[0]),
        .rx_i      (ftdi_txd_i),
        .tx_o      (ftdi_rxd_o),
        .led_o     (led_o)
    );

endmodule

`default_nettype wire

/* test/tb_board_top.sv */
/*
 * Directed tests of the UART-controlled LED PWM SoC through the board pins.
 * The host UART model runs at CLKS_PER_BIT clocks per bit. All waits are bounded.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_board_top import soc_pkg::*;;

    localparam int REPLY_TIMEOUT = 2000;  // Cycles to wait for a start bit
    localparam int QUIET_CYCLES  = 600;
    localparam int FRAME_CYCLES  = 20 * CLKS_PER_BIT;

    logic       clk;
    logic [6:0] btn;
    logic       rx_line;               // Host to FPGA
    wire        tx_line;               // FPGA to host
    wire  [7:0] led_line;

    int          duty_model [NUM_CHANNELS];
    int          mismatch_count = 0;
    int          problem_count  = 0;
    int unsigned rng_state      = 15049;

    board_top i_dut (
        .clk_25mhz  (clk),
        .btn_i      (btn),
        .ftdi_txd_i (rx_line),
        .ftdi_rxd_o (tx_line),
        .led_o      (led_line)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 16;        // Upper bits are the better ones
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int got);
        mismatch_count++;
        $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
    endtask

    task automatic report_problem(input string msg);
        problem_count++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        btn = 7'h00;                   // btn_i[0] low holds reset
        repeat (10) @(negedge clk);
        btn[0] = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    task automatic uart_send_byte(input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_line = bits[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    task automatic send_frame(input logic [7:0] hdr, input logic [7:0] data);
        @(negedge clk);
        uart_send_byte(hdr);
        uart_send_byte(data);
    endtask

    task automatic uart_recv_byte(output logic [7:0] b, output bit ok);
        int waited;
        waited = 0;
        ok     = 1'b0;
        b      = 8'h00;
        @(negedge clk);
        while (tx_line === 1'b1 && waited < REPLY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (tx_line === 1'b1) begin
            report_problem("no start bit on ftdi_rxd_o before timeout");
            return;
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk);   // Middle of start bit
        if (tx_line !== 1'b0) begin
            report_problem("start bit on ftdi_rxd_o did not hold low");
            return;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = tx_line;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (tx_line !== 1'b1) begin
            report_problem("stop bit on ftdi_rxd_o was not high");
            return;
        end
        ok = 1'b1;
    endtask

    // Counters run free modulo 256, so one period gives the duty exactly
    task automatic measure_duty(input int k, output int count);
        count = 0;
        for (int i = 0; i < 256; i++) begin
            @(negedge clk);
            if (led_line[k] === 1'b1) begin
                count++;
            end
        end
    endtask

    task automatic expect_tx_idle(input int cycles);
        int i;
        i = 0;
        while (i < cycles) begin
            @(negedge clk);
            if (tx_line !== 1'b1) begin
                report_problem("unexpected activity on ftdi_rxd_o");
                i = cycles;
            end
            i++;
        end
    endtask

    task automatic expect_leds_dark();
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < 256; i++) begin
            @(negedge clk);
            if (!seen && led_line !== 8'h00) begin
                report_mismatch("led_o", 0, int'(led_line));
                seen = 1'b1;
            end
        end
    endtask

    task automatic set_duty(input int ch, input int duty);
        send_frame({OP_SET_DUTY, 4'(ch)}, 8'(duty));
        duty_model[ch] = duty;
        repeat (2) @(negedge clk);
    endtask

    task automatic get_duty(input int ch, output int val, output bit ok);
        logic [7:0] b;
        fork
            send_frame({OP_GET_DUTY, 4'(ch)}, 8'h00);
            uart_recv_byte(b, ok);
        join
        val = int'(b);
    endtask

    task automatic compare_all_duties();
        int cnt;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            measure_duty(ch, cnt);
            if (cnt !== duty_model[ch]) begin
                report_mismatch($sformatf("led_o[%0d] high count", ch), duty_model[ch], cnt);
            end
        end
    endtask

    task automatic check_idle_after_reset();
        fork
            expect_leds_dark();
            expect_tx_idle(256);
        join
    endtask

    task automatic set_all_duties();
        int d;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            if (ch == 0) begin
                d = 0;
            end else if (ch == NUM_CHANNELS - 1) begin
                d = 255;
            end else begin
                d = int'(next_rand() % 256);
            end
            set_duty(ch, d);
        end
        compare_all_duties();
    endtask

    // One reply per GET, then the line must stay quiet
    task automatic read_back_duties();
        int  v;
        bit  ok;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            get_duty(ch, v, ok);
            if (!ok) begin
                report_problem($sformatf("no valid reply to GET on channel %0d", ch));
            end else if (v !== duty_model[ch]) begin
                report_mismatch($sformatf("GET reply ch %0d", ch), duty_model[ch], v);
            end
            expect_tx_idle(QUIET_CYCLES);
        end
    endtask

    task automatic read_two_channels();
        int         a;
        int         b;
        logic [7:0] r0;
        logic [7:0] r1;
        bit         ok0;
        bit         ok1;
        a = int'(next_rand() % NUM_CHANNELS);
        b = int'((a + 1 + int'(next_rand() % 7)) % NUM_CHANNELS);
        fork
            begin
                send_frame({OP_GET_DUTY, 4'(a)}, 8'h00);
                send_frame({OP_GET_DUTY, 4'(b)}, 8'h00);
            end
            begin
                uart_recv_byte(r0, ok0);
                uart_recv_byte(r1, ok1);
            end
        join
        if (!ok0 || !ok1) begin
            report_problem($sformatf("missing reply to GET pair on channels %0d, %0d", a, b));
        end else if (!((int'(r0) == duty_model[a] && int'(r1) == duty_model[b]) ||
                       (int'(r0) == duty_model[b] && int'(r1) == duty_model[a]))) begin
            report_mismatch("GET pair reply, first byte", duty_model[a], int'(r0));
            report_mismatch("GET pair reply, second byte", duty_model[b], int'(r1));
        end
        expect_tx_idle(QUIET_CYCLES);
    endtask

    task automatic reject_bad_frames();
        fork
            begin
                send_frame({4'd3, 4'd2}, 8'h55);          // Unknown opcode
                send_frame({OP_SET_DUTY, 4'd9}, 8'haa);   // Aliases channel 1
                send_frame({OP_SET_DUTY, 4'd15}, 8'h11);
                send_frame({OP_NOP, 4'd0}, 8'h22);
                send_frame({OP_GET_DUTY, 4'd8}, 8'h00);
            end
            expect_tx_idle(5 * FRAME_CYCLES + REPLY_TIMEOUT);
        join
        compare_all_duties();
    endtask

    task automatic reset_and_reuse();
        int ch;
        int d;
        int cnt;
        apply_reset();
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            duty_model[i] = 0;
        end
        expect_leds_dark();
        read_back_duties();
        ch = int'(next_rand() % NUM_CHANNELS);
        d  = 1 + int'(next_rand() % 255);
        set_duty(ch, d);
        measure_duty(ch, cnt);
        if (cnt !== d) begin
            report_mismatch($sformatf("led_o[%0d] high count after reset", ch), d, cnt);
        end
    endtask

    initial begin
        rx_line = 1'b1;
        btn     = 7'h00;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            duty_model[i] = 0;
        end
        apply_reset();
        check_idle_after_reset();
        set_all_duties();
        read_back_duties();
        read_two_channels();
        reject_bad_frames();
        reset_and_reuse();
        $display("Value mismatches: %0d, other failures: %0d", mismatch_count, problem_count);
        if (mismatch_count == 0 && problem_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ulx3s_pwm_soc.f */
logic/soc_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/cmd_dispatch.sv
logic/pwm_channel.sv
logic/reply_merge.sv
logic/soc_top.sv
logic/board_top.sv
test/tb_board_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator; the log decides pass or fail.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module tb_board_top \
    -f ulx3s_pwm_soc.f \
    -o tb_board_top_sim

./obj_dir/tb_board_top_sim | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi
